// File: Bender.yml
package:
  name: fifo_to_host

sources:
  - include_dirs:
      - src
    files:
      - src/fifo_to_host_pkg.sv
      - src/chunk_line_packer.sv
      - src/message_sequencer.sv
      - src/host_write_former.sv
      - src/fifo_to_host.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/fifo_to_host_tb.sv

// File: fifo_to_host.f
+incdir+src
src/fifo_to_host_pkg.sv
src/chunk_line_packer.sv
src/message_sequencer.sv
src/host_write_former.sv
src/fifo_to_host.sv
test/fifo_to_host_tb.sv

// File: src/chunk_line_packer.sv
//==========================================================================
// Packs chunks into one line buffer. The source may raise chunk_valid only
// while chunk_ready is high, and chunk_ready is combinational
//==========================================================================

`timescale 1ns/1ps

`include "fifo_to_host_params.svh"

module chunk_line_packer
(
    input  logic                         clk,
    input  logic                         resetb,
    input  fifo_to_host_pkg::chunk_t     chunk_data,
    input  logic                         chunk_valid,
    input  logic                         line_deq,
    input  logic                         keep_one,
    input  logic                         force_flush,
    output logic                         chunk_ready,
    output fifo_to_host_pkg::line_t      line_data,
    output logic                         line_full,
    output logic                         line_nonempty,
    output fifo_to_host_pkg::chunk_cnt_t real_chunks
);

    // Slots in use, pad rotations included
    fifo_to_host_pkg::chunk_cnt_t busy_chunks;

    logic chunk_accept;
    logic do_shift;

    // The slot count is a power of two, so the top bit marks a full line
    assign line_full     = busy_chunks[$high(busy_chunks)];
    assign line_nonempty = (busy_chunks != '0);

    // A full line still takes a chunk when the line leaves on the same edge
    assign chunk_ready  = (!line_full || line_deq) && !force_flush;
    assign chunk_accept = chunk_valid && chunk_ready;

    // A forced flush rotates a pad slot in, pushing the partial line down
    // so that the real chunks end up at index 0
    assign do_shift = chunk_accept || (force_flush && !line_full);

    //==========================================================================
    // Line shifter
    //==========================================================================

    always_ff @(posedge clk)
    begin
        if (do_shift)
        begin
            // Older chunks move toward index 0 and the new one lands on top
            for (int i = 0; i < `FTH_CHUNKS_PER_LINE - 1; i++)
            begin
                line_data[i] <= line_data[i + 1];
            end
            line_data[`FTH_CHUNKS_PER_LINE - 1] <= chunk_data;
        end
    end

    //==========================================================================
    // Busy and real chunk counts
    //==========================================================================

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            busy_chunks <= '0;
            real_chunks <= '0;
        end
        else if (line_deq)
        begin
            // What stays is the held-back remainder plus a chunk arriving now
            busy_chunks <= fifo_to_host_pkg::chunk_cnt_t'(keep_one) +
                           fifo_to_host_pkg::chunk_cnt_t'(chunk_accept);
            real_chunks <= fifo_to_host_pkg::chunk_cnt_t'(keep_one) +
                           fifo_to_host_pkg::chunk_cnt_t'(chunk_accept);
        end
        else
        begin
            // Pad slots count as busy but never as real
            busy_chunks <= busy_chunks + fifo_to_host_pkg::chunk_cnt_t'(do_shift);
            real_chunks <= real_chunks + fifo_to_host_pkg::chunk_cnt_t'(chunk_accept);
        end
    end

endmodule

// File: src/fifo_to_host.sv
//==========================================================================
// Host-bound message writer. ring_base and oldest_idx come from the host,
// and a message is complete in memory once its fence is granted
//==========================================================================

`timescale 1ns/1ps

module fifo_to_host
(
    input  logic                          clk,
    input  logic                          resetb,
    input  fifo_to_host_pkg::chunk_t      chunk_data,
    input  logic                          chunk_valid,
    input  fifo_to_host_pkg::line_addr_t  ring_base,
    input  fifo_to_host_pkg::ring_idx_t   oldest_idx,
    input  logic                          write_grant,
    output logic                          chunk_ready,
    output logic                          write_request,
    output fifo_to_host_pkg::write_kind_t write_kind,
    output fifo_to_host_pkg::line_addr_t  write_addr,
    output fifo_to_host_pkg::line_t       write_data,
    output fifo_to_host_pkg::ring_idx_t   next_write_idx
);

    // Packer to sequencer
    logic                         line_full;
    logic                         line_nonempty;
    fifo_to_host_pkg::chunk_cnt_t real_chunks;
    fifo_to_host_pkg::line_t      line_data;

    // Sequencer to packer
    logic line_deq;
    logic keep_one;
    logic force_flush;

    // Sequencer to former
    fifo_to_host_pkg::seq_state_t state;
    fifo_to_host_pkg::line_t      header_line;
    fifo_to_host_pkg::line_t      data_line;
    fifo_to_host_pkg::msg_len_t   msg_len;
    fifo_to_host_pkg::ring_idx_t  header_idx;
    fifo_to_host_pkg::ring_idx_t  data_idx;

    // The status side sees where the next message header will land
    assign next_write_idx = header_idx;

    chunk_line_packer chunk_line_packer_inst
    (
        .clk           (clk),
        .resetb        (resetb),
        .chunk_data    (chunk_data),
        .chunk_valid   (chunk_valid),
        .line_deq      (line_deq),
        .keep_one      (keep_one),
        .force_flush   (force_flush),
        .chunk_ready   (chunk_ready),
        .line_data     (line_data),
        .line_full     (line_full),
        .line_nonempty (line_nonempty),
        .real_chunks   (real_chunks)
    );

    message_sequencer message_sequencer_inst
    (
        .clk           (clk),
        .resetb        (resetb),
        .line_full     (line_full),
        .line_nonempty (line_nonempty),
        .real_chunks   (real_chunks),
        .line_data     (line_data),
        .oldest_idx    (oldest_idx),
        .write_grant   (write_grant),
        .line_deq      (line_deq),
        .keep_one      (keep_one),
        .force_flush   (force_flush),
        .write_request (write_request),
        .state         (state),
        .header_line   (header_line),
        .data_line     (data_line),
        .msg_len       (msg_len),
        .header_idx    (header_idx),
        .data_idx      (data_idx)
    );

    host_write_former host_write_former_inst
    (
        .state       (state),
        .header_line (header_line),
        .data_line   (data_line),
        .msg_len     (msg_len),
        .header_idx  (header_idx),
        .data_idx    (data_idx),
        .ring_base   (ring_base),
        .write_kind  (write_kind),
        .write_addr  (write_addr),
        .write_data  (write_data)
    );

endmodule

// File: src/fifo_to_host_params.svh
//==========================================================================
// Widths and flush thresholds of the host message writer. A line must hold
// a power-of-two number of chunks, and the ring size is 2**RING_IDX_WIDTH
//==========================================================================

`ifndef FIFO_TO_HOST_PARAMS_SVH
`define FIFO_TO_HOST_PARAMS_SVH

// Bits per chunk and per host cache line
`define FTH_CHUNK_WIDTH      128
`define FTH_LINE_WIDTH       512
`define FTH_CHUNKS_PER_LINE  (`FTH_LINE_WIDTH / `FTH_CHUNK_WIDTH)

// Ring of 64 lines in host memory
`define FTH_RING_IDX_WIDTH   6
`define FTH_LINE_ADDR_WIDTH  32

// Top bit of the idle counter fires after 16 idle cycles
`define FTH_IDLE_BITS        5
// Top bit of the active-line counter fires at 8 data lines
`define FTH_MSG_LINES_BITS   4

`endif

// File: src/fifo_to_host_pkg.sv
//==========================================================================
// Types shared by the message writer and its testbench
//==========================================================================

`include "fifo_to_host_params.svh"

package fifo_to_host_pkg;

    typedef logic [`FTH_CHUNK_WIDTH-1:0] chunk_t;

    // A cache line seen as chunks, chunk 0 is the oldest
    typedef logic [`FTH_CHUNKS_PER_LINE-1:0][`FTH_CHUNK_WIDTH-1:0] line_t;

    // Chunk count within a line, one bit wider than the chunk index
    typedef logic [$clog2(`FTH_CHUNKS_PER_LINE):0] chunk_cnt_t;

    typedef logic [`FTH_RING_IDX_WIDTH-1:0] ring_idx_t;
    typedef logic [`FTH_LINE_ADDR_WIDTH-1:0] line_addr_t;

    // Message length in chunks, large enough for the whole ring
    typedef logic [$clog2(`FTH_CHUNKS_PER_LINE) + `FTH_RING_IDX_WIDTH - 1:0] msg_len_t;

    typedef enum logic
    {
        write_thru,
        write_fence
    } write_kind_t;

    typedef enum logic [2:0]
    {
        wait_header,
        wait_data,
        emit_data,
        emit_header,
        emit_fence
    } seq_state_t;

endpackage

// File: src/host_write_former.sv
//==========================================================================
// Combinational write former. Outputs stay steady while the FSM sits in
// an emit state, since they depend only on its registers
//==========================================================================

`timescale 1ns/1ps

`include "fifo_to_host_params.svh"

module host_write_former
(
    input  fifo_to_host_pkg::seq_state_t  state,
    input  fifo_to_host_pkg::line_t       header_line,
    input  fifo_to_host_pkg::line_t       data_line,
    input  fifo_to_host_pkg::msg_len_t    msg_len,
    input  fifo_to_host_pkg::ring_idx_t   header_idx,
    input  fifo_to_host_pkg::ring_idx_t   data_idx,
    input  fifo_to_host_pkg::line_addr_t  ring_base,
    output fifo_to_host_pkg::write_kind_t write_kind,
    output fifo_to_host_pkg::line_addr_t  write_addr,
    output fifo_to_host_pkg::line_t       write_data
);

    fifo_to_host_pkg::line_t stamped_header;

    // Length goes in chunk 0 and the first three captured chunks follow
    assign stamped_header = {header_line[`FTH_CHUNKS_PER_LINE-2:0],
                             fifo_to_host_pkg::chunk_t'(msg_len)};

    always_comb
    begin
        case (state)
            fifo_to_host_pkg::emit_data:
            begin
                write_kind = fifo_to_host_pkg::write_thru;
                write_addr = ring_base + fifo_to_host_pkg::line_addr_t'(data_idx);
                write_data = data_line;
            end
            fifo_to_host_pkg::emit_header:
            begin
                write_kind = fifo_to_host_pkg::write_thru;
                write_addr = ring_base + fifo_to_host_pkg::line_addr_t'(header_idx);
                write_data = stamped_header;
            end
            default:
            begin
                // Fence carries no address
                write_kind = fifo_to_host_pkg::write_fence;
                write_addr = '0;
                write_data = stamped_header;
            end
        endcase
    end

endmodule

// File: src/message_sequencer.sv
//==========================================================================
// Message FSM. Data lines go out first, then the header, then a fence. A
// write completes on request and grant, and the ring keeps one line free
//==========================================================================

`timescale 1ns/1ps

`include "fifo_to_host_params.svh"

module message_sequencer
(
    input  logic                          clk,
    input  logic                          resetb,
    input  logic                          line_full,
    input  logic                          line_nonempty,
    input  fifo_to_host_pkg::chunk_cnt_t  real_chunks,
    input  fifo_to_host_pkg::line_t       line_data,
    input  fifo_to_host_pkg::ring_idx_t   oldest_idx,
    input  logic                          write_grant,
    output logic                          line_deq,
    output logic                          keep_one,
    output logic                          force_flush,
    output logic                          write_request,
    output fifo_to_host_pkg::seq_state_t  state,
    output fifo_to_host_pkg::line_t       header_line,
    output fifo_to_host_pkg::line_t       data_line,
    output fifo_to_host_pkg::msg_len_t    msg_len,
    output fifo_to_host_pkg::ring_idx_t   header_idx,
    output fifo_to_host_pkg::ring_idx_t   data_idx
);

    logic [`FTH_IDLE_BITS-1:0]      idle_cycles;
    logic [`FTH_MSG_LINES_BITS-1:0] active_lines;

    logic flush_for_idle;
    logic flush_for_idle_hold;
    logic flush_full_msg;
    logic flush_full_msg_hold;
    logic in_wait;
    logic allow_write;

    //==========================================================================
    // Flush decisions
    //==========================================================================

    // Each flush cause stays raised until the fence has gone out
    assign flush_for_idle = idle_cycles[$high(idle_cycles)] || flush_for_idle_hold;
    assign flush_full_msg = active_lines[$high(active_lines)] || flush_full_msg_hold;

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            flush_for_idle_hold <= 1'b0;
            flush_full_msg_hold <= 1'b0;
        end
        else
        begin
            flush_for_idle_hold <= flush_for_idle && (state != fifo_to_host_pkg::emit_fence);
            flush_full_msg_hold <= flush_full_msg && (state != fifo_to_host_pkg::emit_fence);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            idle_cycles  <= '0;
            active_lines <= '0;
        end
        else
        begin
            // Idle time only counts while a message is waiting to grow
            if (state == fifo_to_host_pkg::wait_header)
                idle_cycles <= line_nonempty ? idle_cycles + 1'b1 : '0;
            else if ((state != fifo_to_host_pkg::wait_data) || line_deq)
                idle_cycles <= '0;
            else
                idle_cycles <= idle_cycles + 1'b1;

            // Data lines written in the current message
            if (state == fifo_to_host_pkg::emit_header)
                active_lines <= '0;
            else if ((state == fifo_to_host_pkg::emit_data) && write_grant)
                active_lines <= active_lines + 1'b1;
        end
    end

    //==========================================================================
    // Packer controls and write request
    //==========================================================================

    assign in_wait = (state == fifo_to_host_pkg::wait_header) ||
                     (state == fifo_to_host_pkg::wait_data);

    assign force_flush = (state == fifo_to_host_pkg::wait_header) && flush_for_idle;
    assign line_deq    = line_full && !flush_full_msg && in_wait;

    // A full header line leaves its newest chunk behind, since chunk 0 of
    // the header carries the length
    assign keep_one = (state == fifo_to_host_pkg::wait_header) &&
                      real_chunks[$high(real_chunks)];

    // Hold off while the next line would run into the host's oldest line
    assign allow_write   = ((data_idx + fifo_to_host_pkg::ring_idx_t'(1)) != oldest_idx);
    assign write_request = allow_write && !in_wait;

    //==========================================================================
    // State and ring indices
    //==========================================================================

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            state      <= fifo_to_host_pkg::wait_header;
            header_idx <= '0;
            data_idx   <= '0;
        end
        else
        begin
            case (state)
                fifo_to_host_pkg::wait_header:
                begin
                    if (line_full)
                    begin
                        state    <= flush_for_idle ? fifo_to_host_pkg::emit_header
                                                   : fifo_to_host_pkg::wait_data;
                        data_idx <= data_idx + 1'b1;
                    end
                end
                fifo_to_host_pkg::wait_data:
                begin
                    // A full line beats the idle timeout
                    if (flush_full_msg)
                        state <= fifo_to_host_pkg::emit_header;
                    else if (line_full)
                        state <= fifo_to_host_pkg::emit_data;
                    else if (flush_for_idle)
                        state <= fifo_to_host_pkg::emit_header;
                end
                fifo_to_host_pkg::emit_data:
                begin
                    // A message at its line limit leaves from wait_data next
                    if (write_grant)
                    begin
                        state    <= fifo_to_host_pkg::wait_data;
                        data_idx <= data_idx + 1'b1;
                    end
                end
                fifo_to_host_pkg::emit_header:
                begin
                    if (write_grant)
                        state <= fifo_to_host_pkg::emit_fence;
                end
                fifo_to_host_pkg::emit_fence:
                begin
                    if (write_grant)
                    begin
                        state      <= fifo_to_host_pkg::wait_header;
                        // Next message starts at the first unused line
                        header_idx <= data_idx;
                    end
                end
                default:
                begin
                    state <= fifo_to_host_pkg::wait_header;
                end
            endcase
        end
    end

    //==========================================================================
    // Captured lines and message length
    //==========================================================================

    always_ff @(posedge clk)
    begin
        if ((state == fifo_to_host_pkg::wait_header) && line_full)
        begin
            header_line <= line_data;
            msg_len     <= keep_one ? fifo_to_host_pkg::msg_len_t'(`FTH_CHUNKS_PER_LINE - 1)
                                    : fifo_to_host_pkg::msg_len_t'(real_chunks);
        end
        else if ((state == fifo_to_host_pkg::wait_data) && line_full && !flush_full_msg)
        begin
            data_line <= line_data;
            msg_len   <= msg_len + fifo_to_host_pkg::msg_len_t'(`FTH_CHUNKS_PER_LINE);
        end
    end

endmodule

// File: test/fifo_to_host_tb.sv
//==========================================================================
// Testbench for the host message writer. A host ring model decodes each
// framed message at its fence and compares it with the chunks sent
//==========================================================================

`timescale 1ns/1ps

`include "fifo_to_host_params.svh"

module fifo_to_host_tb;

    localparam int CLK_PERIOD      = 100;
    localparam int RING_LINES      = 1 << `FTH_RING_IDX_WIDTH;
    localparam int GRANT_DELAY_MAX = 3;
    localparam int RAND_BURSTS     = 12;
    // Cycle estimate per test for reset, short, long, maximum, ring full and random
    localparam int TEST_CYCLES     = 8 + 3 * 100 + 300 + 400 + 300 + RAND_BURSTS * 250;
    localparam int MARGIN          = 4;

    logic                          clk;
    logic                          resetb;
    fifo_to_host_pkg::chunk_t      chunk_data;
    logic                          chunk_valid;
    fifo_to_host_pkg::line_addr_t  ring_base;
    fifo_to_host_pkg::ring_idx_t   oldest_idx;
    logic                          write_grant;
    logic                          chunk_ready;
    logic                          write_request;
    fifo_to_host_pkg::write_kind_t write_kind;
    fifo_to_host_pkg::line_addr_t  write_addr;
    fifo_to_host_pkg::line_t       write_data;
    fifo_to_host_pkg::ring_idx_t   next_write_idx;

    // Host ring model and scoreboard
    fifo_to_host_pkg::chunk_t    sent_q[$];
    fifo_to_host_pkg::ring_idx_t msg_idx_q[$];
    fifo_to_host_pkg::line_t     ring_mem [RING_LINES];
    fifo_to_host_pkg::ring_idx_t model_idx;
    fifo_to_host_pkg::ring_idx_t ring_gap;
    fifo_to_host_pkg::ring_idx_t last_header_idx;
    int                          last_lines;
    int                          last_len;
    int                          fence_count;
    int                          check_count;
    int                          error_count;
    int                          grant_wait;
    string                       test_name;

    fifo_to_host fifo_to_host_inst
    (
        .clk            (clk),
        .resetb         (resetb),
        .chunk_data     (chunk_data),
        .chunk_valid    (chunk_valid),
        .ring_base      (ring_base),
        .oldest_idx     (oldest_idx),
        .write_grant    (write_grant),
        .chunk_ready    (chunk_ready),
        .write_request  (write_request),
        .write_kind     (write_kind),
        .write_addr     (write_addr),
        .write_data     (write_data),
        .next_write_idx (next_write_idx)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //==========================================================================
    // Checks
    //==========================================================================

    task automatic check_value(input string what,
                               input logic [`FTH_LINE_WIDTH-1:0] expected,
                               input logic [`FTH_LINE_WIDTH-1:0] actual);
        check_count++;
        assert (actual === expected)
        else
        begin
            error_count++;
            $display("** Error [%s] %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic check_true(input logic cond, input string what_failed);
        check_count++;
        assert (cond === 1'b1)
        else
        begin
            error_count++;
            $display("Check failed in test %s: %s", test_name, what_failed);
        end
    endtask

    //==========================================================================
    // Chunk source
    //==========================================================================

    // Sends count chunks with random idle gaps, and only while ready is high
    task automatic send_chunks(input int count, input int max_gap);
        int sent;
        int gap_left;
        sent     = 0;
        gap_left = 0;
        while (sent < count)
        begin
            @(posedge clk);
            #1;
            chunk_valid = 1'b0;
            if (gap_left > 0)
                gap_left--;
            else if (chunk_ready)
            begin
                chunk_data  = {$urandom, $urandom, $urandom, $urandom};
                chunk_valid = 1'b1;
                sent_q.push_back(chunk_data);
                sent++;
                gap_left = $urandom_range(max_gap, 0);
            end
        end
        @(posedge clk);
        #1;
        chunk_valid = 1'b0;
    endtask

    // Polled on the rising edge while the monitor updates on the falling edge
    task automatic wait_drained();
        while (sent_q.size() != 0)
            @(posedge clk);
        repeat (4) @(posedge clk);
    endtask

    task automatic wait_fences(input int target);
        while (fence_count < target)
            @(posedge clk);
    endtask

    //==========================================================================
    // Host side
    //==========================================================================

    // The host consumes each message at once, and ring_gap pulls its oldest
    // line forward to fake a ring that the host has not drained
    // The grant follows the request as it stands before oldest_idx moves
    initial
    begin
        grant_wait = 0;
        forever
        begin
            @(posedge clk);
            #1;
            write_grant = 1'b0;
            if (write_request === 1'b1)
            begin
                if (grant_wait > 0)
                    grant_wait--;
                else
                begin
                    write_grant = 1'b1;
                    grant_wait  = $urandom_range(GRANT_DELAY_MAX, 0);
                end
            end
            oldest_idx = next_write_idx + ring_gap;
        end
    end

    // The header is the last line before the fence and data lines come before it
    task automatic decode_message();
        fifo_to_host_pkg::line_t  header;
        fifo_to_host_pkg::chunk_t got;
        int                       lines;
        int                       len;
        check_value("fence address", 0, write_addr);
        if (msg_idx_q.size() == 0)
        begin
            check_true(1'b0, "a fence arrived with no header line before it");
            return;
        end
        lines = msg_idx_q.size() - 1;
        check_value("header index", model_idx, msg_idx_q[lines]);
        for (int i = 0; i < lines; i++)
            check_value("data line index", fifo_to_host_pkg::ring_idx_t'(model_idx + 1 + i),
                        msg_idx_q[i]);
        check_true(lines <= 8, "a message holds more than eight data lines");
        header = ring_mem[msg_idx_q[lines]];
        if (lines > 0)
        begin
            // A full header reserves one chunk, so three plus four per line
            check_value("message length", 3 + 4 * lines, header[0]);
            len = 3 + 4 * lines;
        end
        else
        begin
            check_true((header[0] >= 1) && (header[0] <= 3),
                       "a short message length lies outside 1 to 3");
            len = int'(header[0][1:0]);
        end
        for (int k = 0; k < len; k++)
        begin
            if (k < 3)
                got = header[k + 1];
            else
                got = ring_mem[msg_idx_q[(k - 3) / `FTH_CHUNKS_PER_LINE]]
                              [(k - 3) % `FTH_CHUNKS_PER_LINE];
            if (sent_q.size() == 0)
                check_true(1'b0, "a message holds more chunks than were sent");
            else
                check_value("message chunk", sent_q.pop_front(), got);
        end
        last_lines      = lines;
        last_len        = len;
        last_header_idx = msg_idx_q[lines];
        model_idx       = model_idx + fifo_to_host_pkg::ring_idx_t'(lines + 1);
        msg_idx_q.delete();
        fence_count++;
    endtask

    // Write monitor samples on the falling edge, where every signal is settled
    initial
    begin
        fifo_to_host_pkg::write_kind_t held_kind;
        fifo_to_host_pkg::line_addr_t  held_addr;
        fifo_to_host_pkg::line_t       held_data;
        fifo_to_host_pkg::ring_idx_t   idx;
        logic                          pending;
        logic                          idx_due;
        pending = 1'b0;
        idx_due = 1'b0;
        @(posedge resetb);
        forever
        begin
            @(negedge clk);
            if (idx_due)
                check_value("next write index", model_idx, next_write_idx);
            idx_due = 1'b0;
            // A request that saw no grant must come back unchanged
            if (pending)
            begin
                check_value("held write_request", 1, write_request);
                check_value("held write kind", held_kind, write_kind);
                check_value("held write address", held_addr, write_addr);
                check_value("held write data", held_data, write_data);
            end
            pending   = write_request && !write_grant;
            held_kind = write_kind;
            held_addr = write_addr;
            held_data = write_data;
            if (write_request && write_grant)
            begin
                if (write_kind == fifo_to_host_pkg::write_thru)
                begin
                    check_true((write_addr - ring_base) < RING_LINES,
                               "a line write fell outside the ring");
                    idx = fifo_to_host_pkg::ring_idx_t'(write_addr - ring_base);
                    ring_mem[idx] = write_data;
                    msg_idx_q.push_back(idx);
                end
                else
                begin
                    decode_message();
                    idx_due = 1'b1;
                end
            end
        end
    end

    //==========================================================================
    // Test sequence
    //==========================================================================

    initial
    begin
        fifo_to_host_pkg::ring_idx_t h0;
        int                          base;
        void'($urandom(32'hbdac));
        check_count = 0;
        error_count = 0;
        fence_count = 0;
        model_idx   = '0;
        ring_gap    = '0;
        test_name   = "reset";
        resetb      = 1'b0;
        chunk_valid = 1'b0;
        chunk_data  = '0;
        ring_base   = 32'h0000_8000;
        oldest_idx  = '0;
        write_grant = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        resetb = 1'b1;
        @(negedge clk);
        check_value("write_request", 0, write_request);
        check_value("chunk_ready", 1, chunk_ready);
        check_value("next_write_idx", 0, next_write_idx);

        // One to three chunks go out as a lone header after the idle flush
        test_name = "short message";
        for (int k = 1; k <= 3; k++)
        begin
            wait_drained();
            h0   = next_write_idx;
            base = fence_count;
            send_chunks(k, 0);
            wait_fences(base + 1);
            check_value("data lines", 0, last_lines);
            check_value("length", k, last_len);
            check_value("header index", h0, last_header_idx);
        end

        // Eleven chunks fill two data lines and two more open the next message
        test_name = "long message";
        wait_drained();
        h0   = next_write_idx;
        base = fence_count;
        send_chunks(13, 0);
        wait_fences(base + 1);
        check_value("data lines", 2, last_lines);
        check_value("length", 11, last_len);
        check_value("header index", h0, last_header_idx);
        wait_fences(base + 2);
        check_value("leftover length", 2, last_len);
        check_value("leftover header index", fifo_to_host_pkg::ring_idx_t'(h0 + 3),
                    last_header_idx);

        test_name = "maximum message";
        wait_drained();
        h0   = next_write_idx;
        base = fence_count;
        send_chunks(40, 0);
        wait_fences(base + 1);
        check_value("data lines", 8, last_lines);
        check_value("length", 35, last_len);
        @(negedge clk);
        check_value("next header index", fifo_to_host_pkg::ring_idx_t'(h0 + 9),
                    next_write_idx);

        // The second data line runs into the oldest line and must wait
        test_name = "ring full";
        wait_drained();
        ring_gap = 3;
        fork
            send_chunks(16, 0);
            begin
                @(negedge clk);
                while (chunk_ready || write_request)
                    @(negedge clk);
                repeat (20)
                begin
                    @(negedge clk);
                    check_value("write_request", 0, write_request);
                    check_value("chunk_ready", 0, chunk_ready);
                end
                ring_gap = '0;
            end
        join
        wait_drained();

        test_name = "random traffic";
        for (int m = 0; m < RAND_BURSTS; m++)
            send_chunks($urandom_range(20, 1), $urandom_range(6, 0));
        wait_drained();

        $display("Checks: %0d, errors: %0d, messages: %0d", check_count, error_count,
                 fence_count);
        if (error_count == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    initial
    begin
        repeat (TEST_CYCLES * MARGIN) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", TEST_CYCLES * MARGIN);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        $display("Some tests failed");
        $finish;
    end

endmodule
